/* Bender.yml */
package:
  name: idct_engine

sources:
  - files:
      - verilog/idct_pkg.sv
      - verilog/block_ram_if.sv
      - verilog/dual_port_ram.sv
      - verilog/dct_coeff_rom.sv
      - verilog/block_fetch.sv
      - verilog/matrix_mac.sv
      - verilog/block_writeback.sv
      - verilog/idct_ctrl.sv
      - verilog/idct_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_idct.sv

/* dv/tb_idct_model.svh */
// reference IDCT model for tb_idct, included in its module body to predict pixels and addresses
`ifndef TB_IDCT_MODEL_SVH
`define TB_IDCT_MODEL_SVH

int cos_table [64];              // C[k][j] at k*8 + j
int coeff_blk [64];              // S'[i][k] at i*8 + k
idct_pkg::pixel_t exp_pix [64];  // S[i][j] at i*8 + j

// 2048*cos((2j+1)*k*pi/16) cut toward zero, row 0 is flat
function automatic void build_cos_table();
	real ang;
	int k;
	int j;
	for (k = 0; k < 8; k++) begin
		for (j = 0; j < 8; j++) begin
			ang = real'((2 * j + 1) * k) * 3.14159265358979 / 16.0;
			if (k == 0)
				cos_table[k * 8 + j] = 1448;
			else
				cos_table[k * 8 + j] = $rtoi(2048.0 * $cos(ang));
		end
	end
endfunction

// word of coefficient S'[r][c] of block (col, row)
function automatic idct_pkg::sram_addr_t coeff_addr(input int col, input int row,
		input int r, input int c);
	return idct_pkg::sram_addr_t'(int'(idct_pkg::PRE_IDCT_BASE)
		+ (row * 8 + r) * int'(idct_pkg::COEFF_ROW_STRIDE) + col * 8 + c);
endfunction

// word holding pixel pair p of pixel row r
function automatic idct_pkg::sram_addr_t pixel_addr(input int col, input int row,
		input int r, input int p);
	return idct_pkg::sram_addr_t'(int'(idct_pkg::Y_OUT_BASE)
		+ (row * 8 + r) * int'(idct_pkg::PIXEL_ROW_STRIDE) + col * 4 + p);
endfunction

// row pass then column pass with clipping, from coeff_blk into exp_pix
function automatic void compute_expected();
	int t_blk [64];
	int sum;
	int i;
	int j;
	int k;
	for (i = 0; i < 8; i++) begin
		for (j = 0; j < 8; j++) begin
			sum = 0;
			for (k = 0; k < 8; k++)
				sum += coeff_blk[i * 8 + k] * cos_table[k * 8 + j];
			t_blk[i * 8 + j] = sum >>> idct_pkg::T_SHIFT;
		end
	end
	for (i = 0; i < 8; i++) begin
		for (j = 0; j < 8; j++) begin
			sum = 0;
			for (k = 0; k < 8; k++)
				sum += cos_table[k * 8 + i] * t_blk[k * 8 + j];
			sum = sum >>> idct_pkg::S_SHIFT;
			if (sum < 0)
				exp_pix[i * 8 + j] = 8'd0;
			else if (sum > 255)
				exp_pix[i * 8 + j] = 8'd255;
			else
				exp_pix[i * 8 + j] = idct_pkg::pixel_t'(sum);
		end
	end
endfunction

`endif

/* dv/tb_idct.sv */
// testbench for idct_top with an SRAM model, runs directed block tests against the IDCT model
`timescale 1ns/100ps

module tb_idct;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_BLOCKS = 8;
	localparam int CYCLES_PER_BLOCK = 600;
	localparam int MARGIN_CYCLES = 2000;
	localparam int RUN_LIMIT = 1000;  // cycles from start to done

	logic Clock;
	logic resetn;
	logic start;
	idct_pkg::blk_col_t block_col;
	idct_pkg::blk_row_t block_row;
	idct_pkg::sram_word_t SRAM_read_data;
	idct_pkg::sram_word_t SRAM_write_data;
	idct_pkg::sram_addr_t SRAM_address;
	logic SRAM_we_n;
	logic done;

	idct_pkg::sram_word_t sram [0:262143];
	idct_pkg::sram_word_t rd_stage1;
	idct_pkg::sram_word_t rd_stage2;
	idct_pkg::sram_addr_t rd_trace [$];  // bus addresses before the first write
	idct_pkg::sram_addr_t wr_addr_q [$];
	idct_pkg::sram_word_t wr_data_q [$];
	logic read_open;
	int seed;
	int err_cnt;

	`include "tb_idct_model.svh"

	idct_top UUT (
		.Clock(Clock), .resetn(resetn), .start(start),
		.block_col(block_col), .block_row(block_row),
		.SRAM_read_data(SRAM_read_data), .SRAM_write_data(SRAM_write_data),
		.SRAM_address(SRAM_address), .SRAM_we_n(SRAM_we_n), .done(done)
	);

	always #(CLK_PERIOD / 2) Clock = ~Clock;

	// two-edge read latency
	always @(posedge Clock) begin
		rd_stage1 <= sram[SRAM_address];
		rd_stage2 <= rd_stage1;
	end

	always @(negedge Clock) SRAM_read_data <= rd_stage2;

	always @(negedge Clock) begin
		if (resetn && SRAM_we_n === 1'b0) begin
			sram[SRAM_address] = SRAM_write_data;
			wr_addr_q.push_back(SRAM_address);
			wr_data_q.push_back(SRAM_write_data);
			read_open = 1'b0;  // read phase is over
		end else if (read_open) begin
			rd_trace.push_back(SRAM_address);
		end
	end

	initial begin
		#(CLK_PERIOD * (NUM_BLOCKS * CYCLES_PER_BLOCK + MARGIN_CYCLES));
		$display("watchdog expired, the IDCT engine never finished all of its blocks");
		fail_and_stop();
	end

	task automatic fail_and_stop();
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_pixel(input string name, input idct_pkg::pixel_t expected,
			input idct_pkg::pixel_t actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
			err_cnt++;
			fail_and_stop();
		end
	endtask

	task automatic check_addr(input string name, input idct_pkg::sram_addr_t expected,
			input idct_pkg::sram_addr_t actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
			err_cnt++;
			fail_and_stop();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
			err_cnt++;
			fail_and_stop();
		end
	endtask

	// background pattern over the full address
	function automatic idct_pkg::sram_word_t fill_word(input idct_pkg::sram_addr_t addr);
		return addr[15:0] ^ {addr[17:16], 14'h1a5b};
	endfunction

	task automatic fill_memory();
		int a;
		for (a = 0; a < 262144; a++)
			sram[a] = fill_word(idct_pkg::sram_addr_t'(a));
	endtask

	task automatic set_dc_block(input int dc);
		int n;
		for (n = 0; n < 64; n++)
			coeff_blk[n] = 0;
		coeff_blk[0] = dc;
	endtask

	task automatic set_random_block();
		int n;
		int rnd;
		for (n = 0; n < 64; n++) begin
			rnd = $random(seed);
			coeff_blk[n] = (rnd & 511) - 256;  // -256 to 255
		end
	endtask

	// coefficients into SRAM, output words back to background, expected pixels
	task automatic prepare_block(input int col, input int row);
		int n;
		idct_pkg::sram_addr_t addr;
		for (n = 0; n < 64; n++)
			sram[coeff_addr(col, row, n / 8, n % 8)] = idct_pkg::sram_word_t'(coeff_blk[n]);
		for (n = 0; n < 32; n++) begin
			addr = pixel_addr(col, row, n / 4, n % 4);
			sram[addr] = fill_word(addr);
		end
		compute_expected();
	endtask

	task automatic run_block(input int col, input int row);
		int cycles;
		@(negedge Clock);
		rd_trace.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
		block_col = idct_pkg::blk_col_t'(col);
		block_row = idct_pkg::blk_row_t'(row);
		start = 1'b1;
		read_open = 1'b1;
		@(negedge Clock);
		start = 1'b0;
		cycles = 0;
		while (done !== 1'b1 && cycles < RUN_LIMIT) begin
			@(negedge Clock);
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("block %0d,%0d: the engine never raised done", col, row);
			fail_and_stop();
		end
	endtask

	// 32 writes in pair order, then stored pixels against the model
	task automatic verify_block(input int col, input int row);
		idct_pkg::sram_word_t word;
		int n;
		if (wr_addr_q.size() != 32) begin
			$display("ERR %0t write count expected 32 actual %0d", $time, wr_addr_q.size());
			err_cnt++;
			fail_and_stop();
		end else begin
			for (n = 0; n < 32; n++) begin
				check_addr("SRAM_address", pixel_addr(col, row, n / 4, n % 4), wr_addr_q[n]);
				word = sram[pixel_addr(col, row, n / 4, n % 4)];
				check_pixel("even pixel", exp_pix[n * 2], word[15:8]);
				check_pixel("odd pixel", exp_pix[n * 2 + 1], word[7:0]);
			end
		end
	endtask

	// every stored pixel of the block against one level
	task automatic expect_uniform_block(input int col, input int row,
			input idct_pkg::pixel_t level);
		idct_pkg::sram_word_t word;
		int n;
		for (n = 0; n < 32; n++) begin
			word = sram[pixel_addr(col, row, n / 4, n % 4)];
			check_pixel("even pixel", level, word[15:8]);
			check_pixel("odd pixel", level, word[7:0]);
		end
	endtask

	task automatic reset_and_single_done();
		check_flag("SRAM_we_n", 1'b1, SRAM_we_n);
		check_flag("done", 1'b0, done);
		set_dc_block(0);
		prepare_block(2, 3);
		run_block(2, 3);
		repeat (40) begin
			@(negedge Clock);
			check_flag("done", 1'b0, done);  // no second pulse
		end
	endtask

	task automatic zero_block_writes();
		idct_pkg::sram_word_t word;
		int n;
		set_dc_block(0);
		prepare_block(0, 0);
		run_block(0, 0);
		verify_block(0, 0);
		for (n = 0; n < 32; n++) begin
			word = wr_data_q[n];
			check_pixel("SRAM_write_data upper", 8'd0, word[15:8]);
			check_pixel("SRAM_write_data lower", 8'd0, word[7:0]);
		end
	endtask

	task automatic dc_block_constant();
		set_dc_block(1024);
		prepare_block(10, 5);
		run_block(10, 5);
		expect_uniform_block(10, 5, exp_pix[0]);  // flat output
		verify_block(10, 5);
	endtask

	task automatic dc_clipping();
		set_dc_block(16000);
		prepare_block(3, 20);
		run_block(3, 20);
		expect_uniform_block(3, 20, 8'd255);
		verify_block(3, 20);
		set_dc_block(-16000);
		prepare_block(4, 21);
		run_block(4, 21);
		expect_uniform_block(4, 21, 8'd0);
		verify_block(4, 21);
	endtask

	task automatic random_blocks_match();
		set_random_block();
		prepare_block(39, 29);
		run_block(39, 29);
		verify_block(39, 29);
		set_random_block();
		prepare_block(20, 15);
		run_block(20, 15);
		verify_block(20, 15);
	endtask

	// burst starts where the first two window words appear in a row
	task automatic check_read_window(input int col, input int row);
		int first;
		int n;
		first = -1;
		for (n = 0; n + 1 < rd_trace.size(); n++) begin
			if (first < 0 && rd_trace[n] === coeff_addr(col, row, 0, 0)
					&& rd_trace[n + 1] === coeff_addr(col, row, 0, 1))
				first = n;
		end
		if (first < 0 || first + 64 > rd_trace.size()) begin
			$display("block %0d,%0d: the 64 coefficient reads never appeared on the bus", col, row);
			fail_and_stop();
		end else begin
			for (n = 0; n < 64; n++)
				check_addr("SRAM_address", coeff_addr(col, row, n / 8, n % 8), rd_trace[first + n]);
		end
	endtask

	task automatic read_addresses_in_window();
		set_random_block();
		prepare_block(7, 12);
		run_block(7, 12);
		check_read_window(7, 12);
		verify_block(7, 12);
	endtask

	initial begin
		Clock = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		block_col = '0;
		block_row = '0;
		SRAM_read_data = '0;
		read_open = 1'b0;
		seed = 60;
		err_cnt = 0;
		build_cos_table();
		fill_memory();
		repeat (3) @(negedge Clock);
		resetn = 1'b1;
		reset_and_single_done();
		zero_block_writes();
		dc_block_constant();
		dc_clipping();
		random_blocks_match();
		read_addresses_in_window();
		if (err_cnt == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_and_stop();
		end
	end

endmodule

/* filelist.f */
+incdir+dv
verilog/idct_pkg.sv
verilog/block_ram_if.sv
verilog/dual_port_ram.sv
verilog/dct_coeff_rom.sv
verilog/block_fetch.sv
verilog/matrix_mac.sv
verilog/block_writeback.sv
verilog/idct_ctrl.sv
verilog/idct_top.sv
dv/tb_idct.sv

/* verilog/block_fetch.sv */
// reads one 8x8 block of S' from SRAM and packs coefficient pairs into the S' buffer
`timescale 1ns/100ps

module block_fetch (
	input logic Clock,
	input logic resetn,
	input logic fetch_go,
	input idct_pkg::blk_col_t block_col,
	input idct_pkg::blk_row_t block_row,
	input idct_pkg::sram_word_t SRAM_read_data,
	output idct_pkg::sram_addr_t fetch_addr,
	output logic fetch_done,
	block_ram_if.writer sp_buf
);

	logic active;
	logic [2:0] col;
	logic [2:0] row;
	idct_pkg::sram_addr_t row_base;
	logic [idct_pkg::SRAM_READ_LATENCY-1:0] rd_pipe;  // tracks reads in flight
	logic data_valid;
	logic [5:0] rx_cnt;  // coefficients received
	idct_pkg::sram_word_t even_hold;
	idct_pkg::sp_addr_t pair_addr;

	assign fetch_addr = row_base + idct_pkg::sram_addr_t'(col);
	assign data_valid = rd_pipe[idct_pkg::SRAM_READ_LATENCY-1];
	assign pair_addr = rx_cnt[5:1];

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			active <= 1'b0;
			col <= 3'd0;
			row <= 3'd0;
			row_base <= '0;
			rd_pipe <= '0;
			rx_cnt <= 6'd0;
			sp_buf.wr_en <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			rd_pipe <= {rd_pipe[idct_pkg::SRAM_READ_LATENCY-2:0], active};
			sp_buf.wr_en <= data_valid && rx_cnt[0];  // odd coefficient completes a pair
			fetch_done <= data_valid && (rx_cnt == 6'd63);
			if (data_valid) begin
				rx_cnt <= rx_cnt + 6'd1;
			end
			if (fetch_go) begin
				active <= 1'b1;
				col <= 3'd0;
				row <= 3'd0;
				rx_cnt <= 6'd0;
				// block origin in the coefficient plane
				row_base <= idct_pkg::PRE_IDCT_BASE
					+ idct_pkg::sram_addr_t'({block_row, 3'b000}) * idct_pkg::COEFF_ROW_STRIDE
					+ idct_pkg::sram_addr_t'({block_col, 3'b000});
			end else if (active) begin
				if (col == 3'(idct_pkg::BLOCK_SIZE - 1)) begin
					col <= 3'd0;
					row <= row + 3'd1;
					row_base <= row_base + idct_pkg::COEFF_ROW_STRIDE;  // next coefficient row
					if (row == 3'(idct_pkg::BLOCK_SIZE - 1)) begin
						active <= 1'b0;
					end
				end else begin
					col <= col + 3'd1;
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (data_valid) begin
			if (!rx_cnt[0]) begin
				even_hold <= SRAM_read_data;
			end else begin
				sp_buf.wr_data <= {even_hold, SRAM_read_data};  // even in upper half
				sp_buf.wr_addr <= {1'b0, pair_addr};
			end
		end
	end

	// the burst ends with the 64th coefficient, so pairs never wrap past address 31
	assert property (@(posedge Clock) disable iff (!resetn)
		data_valid && (rx_cnt == 6'd63) |=> !data_valid);

endmodule

/* verilog/block_ram_if.sv */
// read and write ports of one embedded block RAM, shared by its producer and consumer
`timescale 1ns/100ps

interface block_ram_if;

	idct_pkg::t_addr_t rd_addr;
	idct_pkg::ram_word_t rd_data;  // valid the cycle after rd_addr
	idct_pkg::t_addr_t wr_addr;
	idct_pkg::ram_word_t wr_data;
	logic wr_en;  // one cycle per word

	modport writer (
		output wr_addr, wr_data, wr_en
	);

	modport reader (
		output rd_addr,
		input rd_data
	);

	modport ram (
		input rd_addr, wr_addr, wr_data, wr_en,
		output rd_data
	);

endinterface

/* verilog/block_writeback.sv */
// turns pixel-pair strobes into single-cycle SRAM writes in the Y output plane
`timescale 1ns/100ps

module block_writeback (
	input logic Clock,
	input logic resetn,
	input logic pix_valid,
	input idct_pkg::pixel_t [1:0] pix_pair,
	input logic [4:0] pix_index,
	input idct_pkg::blk_col_t block_col,
	input idct_pkg::blk_row_t block_row,
	output idct_pkg::sram_addr_t wb_addr,
	output idct_pkg::sram_word_t wb_data,
	output logic wb_we,
	output logic wb_idle
);

	logic [7:0] pix_row;  // pixel row in the plane
	logic [7:0] pix_word;  // word within the pixel row

	// block position is held by the host for the whole run
	assign pix_row = {block_row, pix_index[4:2]};
	assign pix_word = {block_col, pix_index[1:0]};

	assign wb_idle = !wb_we;

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= pix_valid;  // one write cycle per pair
		end
	end

	always_ff @(posedge Clock) begin
		if (pix_valid) begin
			wb_addr <= idct_pkg::Y_OUT_BASE
				+ idct_pkg::sram_addr_t'(pix_row) * idct_pkg::PIXEL_ROW_STRIDE
				+ idct_pkg::sram_addr_t'(pix_word);
			wb_data <= {pix_pair[1], pix_pair[0]};  // even pixel in upper byte
		end
	end

	// the column pass never strobes back to back, so no buffering is needed here
	assert property (@(posedge Clock) disable iff (!resetn)
		pix_valid |=> !pix_valid);

endmodule

/* verilog/dct_coeff_rom.sv */
// cosine table C[k][j] scaled by 2048, two combinational lookups by index k*8 + j
`timescale 1ns/100ps

module dct_coeff_rom (
	input logic [5:0] coef_sel_a,
	input logic [5:0] coef_sel_b,
	output idct_pkg::coeff_t coef_a,
	output idct_pkg::coeff_t coef_b
);

	// C[k][j] = 2048*cos((2j+1)*k*pi/16), row 0 scaled by 1/sqrt(2)
	function automatic idct_pkg::coeff_t cos_entry(input logic [5:0] idx);
		logic [6:0] prod;
		logic [4:0] ang;
		logic [4:0] fold;
		logic [4:0] mag_sel;
		logic neg;
		idct_pkg::coeff_t mag;
		prod = {3'b000, idx[2:0], 1'b1} * {4'b0000, idx[5:3]};  // (2j+1)*k
		ang = prod[4:0];                      // angle mod 2pi, in pi/16
		fold = ang[4] ? (5'd0 - ang) : ang;   // cos is even
		neg = (fold > 5'd8);                  // second quadrant
		mag_sel = neg ? (5'd16 - fold) : fold;
		case (mag_sel)
			5'd1: mag = 16'sd2008;
			5'd2: mag = 16'sd1892;
			5'd3: mag = 16'sd1702;
			5'd4: mag = 16'sd1448;
			5'd5: mag = 16'sd1137;
			5'd6: mag = 16'sd783;
			5'd7: mag = 16'sd399;
			default: mag = 16'sd1448;  // row 0
		endcase
		return neg ? -mag : mag;
	endfunction

	assign coef_a = cos_entry(coef_sel_a);
	assign coef_b = cos_entry(coef_sel_b);

endmodule

/* verilog/dual_port_ram.sv */
// 64-word embedded RAM with a registered read port and a write port, holds S' or T
`timescale 1ns/100ps

module dual_port_ram (
	input logic Clock,
	block_ram_if.ram port
);

	idct_pkg::ram_word_t mem [64];

	always_ff @(posedge Clock) begin
		if (port.wr_en) begin
			mem[port.wr_addr] <= port.wr_data;
		end
		port.rd_data <= mem[port.rd_addr];  // old data on a same-address write
	end

endmodule

/* verilog/idct_ctrl.sv */
// phase sequencer of the IDCT engine, owns the SRAM port and reports completion
`timescale 1ns/100ps

module idct_ctrl (
	input logic Clock,
	input logic resetn,
	input logic start,
	input logic fetch_done,
	input logic pass_done,
	input logic wb_idle,
	input idct_pkg::sram_addr_t fetch_addr,
	input idct_pkg::sram_addr_t wb_addr,
	input idct_pkg::sram_word_t wb_data,
	input logic wb_we,
	output logic fetch_go,
	output logic row_go,
	output logic col_go,
	output idct_pkg::sram_addr_t SRAM_address,
	output idct_pkg::sram_word_t SRAM_write_data,
	output logic SRAM_we_n,
	output logic done
);

	idct_pkg::idct_phase_t state;

	// fetch reads during FETCH, pixel writes otherwise
	assign SRAM_address = (state == idct_pkg::FETCH) ? fetch_addr : wb_addr;
	assign SRAM_write_data = wb_data;
	assign SRAM_we_n = (state == idct_pkg::FETCH) ? 1'b1 : !wb_we;

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			state <= idct_pkg::IDLE;
			fetch_go <= 1'b0;
			row_go <= 1'b0;
			col_go <= 1'b0;
			done <= 1'b0;
		end else begin
			fetch_go <= 1'b0;
			row_go <= 1'b0;
			col_go <= 1'b0;
			done <= 1'b0;
			case (state)
				idct_pkg::IDLE: begin
					if (start) begin
						fetch_go <= 1'b1;
						state <= idct_pkg::FETCH;
					end
				end
				idct_pkg::FETCH: begin
					if (fetch_done) begin
						row_go <= 1'b1;  // S' buffer complete
						state <= idct_pkg::ROW_PASS;
					end
				end
				idct_pkg::ROW_PASS: begin
					if (pass_done) begin
						col_go <= 1'b1;  // T buffer complete
						state <= idct_pkg::COL_PASS;
					end
				end
				idct_pkg::COL_PASS: begin
					if (pass_done) state <= idct_pkg::DRAIN;
				end
				idct_pkg::DRAIN: begin
					if (wb_idle) state <= idct_pkg::FINISH;  // last pair is in SRAM
				end
				idct_pkg::FINISH: begin
					done <= 1'b1;
					state <= idct_pkg::IDLE;
				end
				default: state <= idct_pkg::IDLE;
			endcase
		end
	end

	// done only after the final pixel write has left the port
	assert property (@(posedge Clock) disable iff (!resetn)
		!(done && !SRAM_we_n));

endmodule

/* verilog/idct_pkg.sv */
// shared widths, SRAM layout constants and controller states for the 8x8 IDCT engine
package idct_pkg;

	// SRAM side
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;

	// arithmetic
	typedef logic signed [15:0] coeff_t;  // S' coefficient or cosine entry
	typedef logic signed [31:0] acc_t;    // accumulator, T before packing
	typedef logic [7:0] pixel_t;

	// block position in the Y plane
	typedef logic [5:0] blk_col_t;  // 0 to 39
	typedef logic [4:0] blk_row_t;  // 0 to 29

	// embedded RAMs
	typedef logic [4:0] sp_addr_t;   // 32 coefficient pairs
	typedef logic [5:0] t_addr_t;    // 64 words
	typedef logic [31:0] ram_word_t;

	// SRAM memory map
	localparam sram_addr_t PRE_IDCT_BASE = 18'd76800;
	localparam sram_addr_t Y_OUT_BASE = 18'd0;
	localparam sram_addr_t COEFF_ROW_STRIDE = 18'd320;  // one coefficient per word
	localparam sram_addr_t PIXEL_ROW_STRIDE = 18'd160;  // two pixels per word

	localparam int BLOCK_SIZE = 8;

	// fixed point scaling of the two passes
	localparam int T_SHIFT = 8;
	localparam int S_SHIFT = 16;

	localparam int SRAM_READ_LATENCY = 2;  // cycles from address to data

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		ROW_PASS,
		COL_PASS,
		DRAIN,
		FINISH
	} idct_phase_t;

endpackage

/* verilog/idct_top.sv */
// top level of the 8x8 luma IDCT engine, connects the units to the external SRAM
`timescale 1ns/100ps

module idct_top (
	input logic Clock,
	input logic resetn,
	input logic start,
	input idct_pkg::blk_col_t block_col,
	input idct_pkg::blk_row_t block_row,
	input idct_pkg::sram_word_t SRAM_read_data,
	output idct_pkg::sram_word_t SRAM_write_data,
	output idct_pkg::sram_addr_t SRAM_address,
	output logic SRAM_we_n,
	output logic done
);

	logic fetch_go;
	logic row_go;
	logic col_go;
	logic fetch_done;
	logic pass_done;
	logic wb_idle;
	logic wb_we;
	logic pix_valid;
	idct_pkg::sram_addr_t fetch_addr;
	idct_pkg::sram_addr_t wb_addr;
	idct_pkg::sram_word_t wb_data;
	idct_pkg::pixel_t [1:0] pix_pair;
	logic [4:0] pix_index;
	logic [5:0] coef_sel_a;
	logic [5:0] coef_sel_b;
	idct_pkg::coeff_t coef_a;
	idct_pkg::coeff_t coef_b;

	block_ram_if sp_buf ();  // S' pairs
	block_ram_if t_buf ();   // packed T pairs

	idct_ctrl ctrl_unit (
		.Clock(Clock), .resetn(resetn), .start(start),
		.fetch_done(fetch_done), .pass_done(pass_done), .wb_idle(wb_idle),
		.fetch_addr(fetch_addr), .wb_addr(wb_addr), .wb_data(wb_data), .wb_we(wb_we),
		.fetch_go(fetch_go), .row_go(row_go), .col_go(col_go),
		.SRAM_address(SRAM_address), .SRAM_write_data(SRAM_write_data),
		.SRAM_we_n(SRAM_we_n), .done(done)
	);

	block_fetch fetch_unit (
		.Clock(Clock), .resetn(resetn), .fetch_go(fetch_go),
		.block_col(block_col), .block_row(block_row), .SRAM_read_data(SRAM_read_data),
		.fetch_addr(fetch_addr), .fetch_done(fetch_done), .sp_buf(sp_buf)
	);

	matrix_mac mac_unit (
		.Clock(Clock), .resetn(resetn), .row_go(row_go), .col_go(col_go),
		.pass_done(pass_done), .pix_valid(pix_valid), .pix_pair(pix_pair),
		.pix_index(pix_index), .coef_sel_a(coef_sel_a), .coef_sel_b(coef_sel_b),
		.coef_a(coef_a), .coef_b(coef_b),
		.sp_buf(sp_buf), .t_wr(t_buf), .t_rd(t_buf)
	);

	block_writeback wb_unit (
		.Clock(Clock), .resetn(resetn), .pix_valid(pix_valid), .pix_pair(pix_pair),
		.pix_index(pix_index), .block_col(block_col), .block_row(block_row),
		.wb_addr(wb_addr), .wb_data(wb_data), .wb_we(wb_we), .wb_idle(wb_idle)
	);

	dual_port_ram sp_ram (.Clock(Clock), .port(sp_buf));
	dual_port_ram t_ram (.Clock(Clock), .port(t_buf));

	dct_coeff_rom coeff_rom (
		.coef_sel_a(coef_sel_a), .coef_sel_b(coef_sel_b),
		.coef_a(coef_a), .coef_b(coef_b)
	);

endmodule

/* verilog/matrix_mac.sv */
// two-multiplier accumulator running the row pass into T and the column pass to pixels
`timescale 1ns/100ps

module matrix_mac (
	input logic Clock,
	input logic resetn,
	input logic row_go,
	input logic col_go,
	output logic pass_done,
	output logic pix_valid,
	output idct_pkg::pixel_t [1:0] pix_pair,
	output logic [4:0] pix_index,
	output logic [5:0] coef_sel_a,
	output logic [5:0] coef_sel_b,
	input idct_pkg::coeff_t coef_a,
	input idct_pkg::coeff_t coef_b,
	block_ram_if.reader sp_buf,
	block_ram_if.writer t_wr,
	block_ram_if.reader t_rd
);

	logic run;
	logic is_col;  // column pass
	logic [1:0] beat;
	logic [5:0] elem;
	logic v1;
	logic [1:0] beat1;
	logic [5:0] elem1;
	logic last_beat;
	logic [2:0] sel_col;
	idct_pkg::sp_addr_t sp_addr;
	idct_pkg::coeff_t op_a;
	idct_pkg::coeff_t op_b;
	idct_pkg::acc_t prod_a;
	idct_pkg::acc_t prod_b;
	idct_pkg::acc_t acc;
	idct_pkg::acc_t sum;
	idct_pkg::acc_t t_shift;
	idct_pkg::acc_t s_shift;
	idct_pkg::coeff_t t_sat;
	idct_pkg::coeff_t t_hold;
	idct_pkg::pixel_t pix;
	idct_pkg::pixel_t pix_hold;

	// row pass: elem = {q, j, r} for S' row 2q+r, T column j
	// column pass: elem = {i, j} for output pixel S[i][j]
	assign sp_addr = {elem[5:4], elem[0], beat};
	assign sp_buf.rd_addr = {1'b0, sp_addr};
	assign t_rd.rd_addr = {1'b0, beat, elem[2:0]};  // word holds T rows 2q and 2q+1
	assign sel_col = is_col ? elem[5:3] : elem[3:1];

	// stage 1, RAM data and table entries line up here
	assign op_a = is_col ? t_rd.rd_data[31:16] : sp_buf.rd_data[31:16];
	assign op_b = is_col ? t_rd.rd_data[15:0] : sp_buf.rd_data[15:0];
	assign prod_a = idct_pkg::acc_t'(op_a) * idct_pkg::acc_t'(coef_a);
	assign prod_b = idct_pkg::acc_t'(op_b) * idct_pkg::acc_t'(coef_b);
	assign sum = ((beat1 == 2'd0) ? idct_pkg::acc_t'(0) : acc) + prod_a + prod_b;
	assign last_beat = v1 && (beat1 == 2'd3);

	assign t_shift = sum >>> idct_pkg::T_SHIFT;
	assign s_shift = sum >>> idct_pkg::S_SHIFT;

	always_comb begin
		if (t_shift > 32'sd32767)
			t_sat = 16'sh7fff;  // saturate to fit a packed T half
		else if (t_shift < -32'sd32768)
			t_sat = 16'sh8000;
		else
			t_sat = t_shift[15:0];
	end

	always_comb begin
		if (s_shift[31])
			pix = 8'd0;
		else if (s_shift > 32'sd255)
			pix = 8'd255;
		else
			pix = s_shift[7:0];  // sum bits 23..16
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			run <= 1'b0;
			is_col <= 1'b0;
			beat <= 2'd0;
			elem <= 6'd0;
			v1 <= 1'b0;
			beat1 <= 2'd0;
			elem1 <= 6'd0;
			t_wr.wr_en <= 1'b0;
			pix_valid <= 1'b0;
			pass_done <= 1'b0;
		end else begin
			v1 <= run;
			beat1 <= beat;
			elem1 <= elem;
			t_wr.wr_en <= last_beat && !is_col && elem1[0];  // odd row closes a T pair
			pix_valid <= last_beat && is_col && elem1[0];   // odd column closes a pixel pair
			pass_done <= last_beat && (elem1 == 6'd63);
			if (row_go || col_go) begin
				run <= 1'b1;
				is_col <= col_go;
				beat <= 2'd0;
				elem <= 6'd0;
			end else if (run) begin
				beat <= beat + 2'd1;
				if (beat == 2'd3) begin
					elem <= elem + 6'd1;
					if (elem == 6'd63) begin
						run <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		coef_sel_a <= {beat, 1'b0, sel_col};  // C[2b][x]
		coef_sel_b <= {beat, 1'b1, sel_col};  // C[2b+1][x]
		if (v1) begin
			acc <= sum;
		end
		if (last_beat) begin
			if (!elem1[0]) begin
				t_hold <= t_sat;
				pix_hold <= pix;
			end
			t_wr.wr_data <= {t_hold, t_sat};
			t_wr.wr_addr <= {1'b0, elem1[5:4], elem1[3:1]};
			pix_pair <= {pix_hold, pix};  // even pixel in [1]
			pix_index <= elem1[5:1];
		end
	end

endmodule
